// File: Bender.yml
package:
  name: cpu_multicycle

sources:
  - rtl/cpuPkg.sv
  - rtl/unifiedRam.sv
  - rtl/memArbiter.sv
  - rtl/fetchSequencer.sv
  - rtl/registerBank.sv
  - rtl/masterAlu.sv
  - rtl/memoryControl.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - dv/cpuTb.sv

// File: dv/cpuTb.sv
// Testbench for the multicycle CPU, loads programs, runs them and checks against a model
`timescale 1ns/1ns

module cpuTb;
  import cpuPkg::*;

  localparam int ResetCycles = 5;
  localparam int HaltLinger  = 10;    // Cycles kept running after HALT
  // 256 load cycles plus ~60 instructions at 8 cycles worst case, doubled with margin
  localparam int CycleLimit  = 2000;

  logic                    clk;
  logic                    rstN;
  logic                    run;
  logic                    progWe;
  logic [AddrWidth-1:0]    progAddr;
  logic [DataWidth-1:0]    progData;
  logic [RegAddrWidth-1:0] dbgAddr;
  logic [DataWidth-1:0]    dbgData;
  logic [AddrWidth-1:0]    pc;
  logic [3:0]              flags;
  logic                    retire;
  logic                    halted;

  // Reference model state
  logic [DataWidth-1:0] mRegs [16];
  logic [DataWidth-1:0] mMem [RamDepth];  // Mirror of RAM
  logic [3:0]           mFlags;
  logic [AddrWidth-1:0] mPc;
  logic                 mHalted;
  logic                 brTaken;          // Last retired instruction was a taken B
  logic [AddrWidth-1:0] brTarget;

  logic [DataWidth-1:0] prog [$];         // Program being assembled
  logic [31:0]          rngState;
  int                   errCount;
  int                   testErrBase;
  int                   testsRun;
  int                   testsFailed;
  int                   cycles;

  cpuTop u_dut (
    .Clk_i(clk), .rstN_i(rstN), .run_i(run),
    .progWe_i(progWe), .progAddr_i(progAddr), .progData_i(progData),
    .dbgAddr_i(dbgAddr), .dbgData_o(dbgData),
    .pc_o(pc), .flags_o(flags), .retire_o(retire), .halted_o(halted)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CycleLimit)
    begin
      $display("Timeout: run did not finish within %0d cycles", CycleLimit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic reportError(input string msg);
    errCount++;
    $display("error %0t: %s", $time, msg);
  endtask

  function automatic logic [31:0] xorshift();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // ARM meaning of the condition codes
  function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] f);
    case (cond)
      CondAl:  return 1'b1;
      CondEq:  return f[FlagZ];
      CondNe:  return !f[FlagZ];
      CondLt:  return f[FlagN] ^ f[FlagV];
      CondGe:  return !(f[FlagN] ^ f[FlagV]);
      default: return 1'b0;
    endcase
  endfunction

  // One architectural step per retire, checks pc before and flags after
  task automatic stepModel();
    logic [DataWidth-1:0] ins;
    logic [DataWidth-1:0] a;
    logic [DataWidth-1:0] b;
    logic [DataWidth-1:0] res;
    logic [DataWidth:0]   wide;     // Sign-extended result
    logic [3:0]           op;
    logic                 c;
    logic                 v;
    logic                 wr;
    ins     = mMem[mPc];
    op      = ins[OpMsb -: 4];
    a       = mRegs[ins[Rs1Msb -: 4]];
    b       = mRegs[ins[Rs2Msb -: 4]];
    res     = '0;
    c       = mFlags[FlagC];  // Logic ops leave C and V alone
    v       = mFlags[FlagV];
    wr      = !(op inside {OpCmp, OpStr, OpB, OpHalt});
    brTaken = 1'b0;
    assert (pc == mPc)
      else reportError($sformatf("retired pc %0d, expected %0d", pc, mPc));
    if (condHolds(ins[CondMsb -: 4], mFlags))
    begin
      case (op)
        OpAdd:
        begin
          res  = a + b;
          c    = (res < a);  // Wrapped past 2^32
          wide = {a[DataWidth-1], a} + {b[DataWidth-1], b};
          v    = wide[DataWidth] != wide[DataWidth-1];
        end
        OpSub, OpCmp:
        begin
          res  = a - b;
          c    = (a >= b);  // No borrow
          wide = {a[DataWidth-1], a} - {b[DataWidth-1], b};
          v    = wide[DataWidth] != wide[DataWidth-1];
        end
        OpAnd: res = a & b;
        OpOrr: res = a | b;
        OpEor: res = a ^ b;
        OpLsl: res = a << ins[ShMsb -: 5];
        OpLsr: res = a >> ins[ShMsb -: 5];
        OpMov: res = DataWidth'(ins[ImmMsb:ImmLsb]);
        OpLdr: res = mMem[a[AddrWidth-1:0]];
        OpStr: mMem[a[AddrWidth-1:0]] = b;
        OpB:
        begin
          brTaken  = 1'b1;
          brTarget = ins[ImmLsb +: AddrWidth];
        end
        OpHalt: mHalted = 1'b1;
        default: wr = 1'b0;
      endcase
      if (wr)
        mRegs[ins[RdMsb -: 4]] = res;
      if ((op inside {[OpAdd:OpCmp]}) && (ins[SBit] || op == OpCmp))
      begin
        mFlags[FlagN] = res[DataWidth-1];
        mFlags[FlagZ] = (res == '0);
        mFlags[FlagC] = c;
        mFlags[FlagV] = v;
      end
    end
    mPc = brTaken ? brTarget : mPc + 1'b1;
    assert (flags == mFlags)
      else reportError($sformatf("flags %b after pc %0d, expected %b", flags, pc, mFlags));
  endtask

  // Model runs on the falling edge, DUT outputs settled
  always @(negedge clk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 16; i++)
        mRegs[i] = '0;
      mFlags   = '0;
      mPc      = '0;
      mHalted  = 1'b0;
      brTaken  = 1'b0;
      brTarget = '0;
    end
    else if (retire)
      stepModel();
  end

  idleWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
    (!run && !$past(run)) |-> (!retire && !halted && pc == '0))
    else reportError($sformatf("core active while stopped, pc %0d", pc));

  branchLands: assert property (@(posedge clk) disable iff (!rstN)
    (retire && brTaken) |=> (pc == brTarget))
    else reportError($sformatf("pc %0d after branch, expected %0d", pc, brTarget));

  haltRaised: assert property (@(posedge clk) disable iff (!rstN)
    (retire && mHalted) |=> halted)
    else reportError("halted_o did not rise after HALT retired");

  haltHolds: assert property (@(posedge clk) disable iff (!rstN)
    (halted && run) |=> (halted && !retire))
    else reportError("core left the halted state or retired after HALT");

  // Pushes one instruction word
  task automatic assemble(input logic [3:0] cond, input logic [3:0] op, input logic s,
                          input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2,
                          input logic [4:0] sh);
    logic [DataWidth-1:0] w;
    w               = '0;
    w[CondMsb -: 4] = cond;
    w[OpMsb -: 4]   = op;
    w[SBit]         = s;
    w[RdMsb -: 4]   = rd;
    w[Rs2Msb -: 4]  = rs2;
    w[Rs1Msb -: 4]  = rs1;
    w[ShMsb -: 5]   = sh;
    prog.push_back(w);
  endtask

  task automatic movImm(input logic [3:0] cond, input logic [3:0] rd, input logic [15:0] imm);
    logic [DataWidth-1:0] w;
    assemble(cond, OpMov, 1'b0, rd, 4'd0, 4'd0, 5'd0);
    w = prog.pop_back();
    w[ImmMsb:ImmLsb] = imm;
    prog.push_back(w);
  endtask

  task automatic branchTo(input logic [3:0] cond, input logic [AddrWidth-1:0] target);
    logic [DataWidth-1:0] w;
    assemble(cond, OpB, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0);
    w = prog.pop_back();
    w[ImmLsb +: AddrWidth] = target;  // Absolute
    prog.push_back(w);
  endtask

  // Full 32-bit constant from two immediates, tmp is clobbered
  task automatic loadConst(input logic [3:0] rd, input logic [3:0] tmp, input logic [31:0] value);
    movImm(CondAl, rd, value[31:16]);
    assemble(CondAl, OpLsl, 1'b0, rd, rd, 4'd0, 5'd16);
    movImm(CondAl, tmp, value[15:0]);
    assemble(CondAl, OpOrr, 1'b0, rd, rd, tmp, 5'd0);
  endtask

  // Program from address 0, then one data word through the same port
  task automatic loadProgram(input logic [AddrWidth-1:0] slotAddr,
                             input logic [DataWidth-1:0] slotData);
    foreach (prog[i])
    begin
      @(posedge clk);
      progWe   <= 1'b1;
      progAddr <= AddrWidth'(i);
      progData <= prog[i];
      mMem[i]  = prog[i];
    end
    @(posedge clk);
    progAddr <= slotAddr;
    progData <= slotData;
    mMem[slotAddr] = slotData;
    @(posedge clk);
    progWe <= 1'b0;
  endtask

  task automatic checkRegisters();
    for (int i = 0; i < 16; i++)
    begin
      @(posedge clk);
      dbgAddr <= RegAddrWidth'(i);
      @(negedge clk);
      assert (dbgData == mRegs[i])
        else reportError($sformatf("r%0d reads %h, expected %h", i, dbgData, mRegs[i]));
    end
  endtask

  task automatic runProgram();
    @(posedge clk);
    run <= 1'b1;
    while (!halted)
      @(negedge clk);
    repeat (HaltLinger) @(posedge clk);  // Window for stray retires
    assert (mHalted)
      else reportError("core halted before the model reached a HALT");
    checkRegisters();
    @(posedge clk);
    run <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic resetCore();
    @(posedge clk);
    rstN <= 1'b0;
    run  <= 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    prog.delete();
    testErrBase = errCount;
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errCount != testErrBase)
      testsFailed++;
    $display("test %s: %s, %0d errors", name,
             (errCount == testErrBase) ? "ok" : "bad", errCount - testErrBase);
  endtask

  task automatic aluTest();
    logic [3:0]  ops [7];
    logic [31:0] rnd;
    resetCore();
    ops = '{OpAdd, OpSub, OpAnd, OpOrr, OpEor, OpLsl, OpLsr};
    for (int r = 1; r <= 6; r++)
      loadConst(4'(r), 4'd14, xorshift());  // r14 scratch
    for (int k = 0; k < 14; k++)
    begin
      rnd = xorshift();
      assemble(CondAl, ops[k % 7], rnd[20], 4'd1 + 4'(rnd % 13),
               4'd1 + 4'((rnd >> 4) % 13), 4'd1 + 4'((rnd >> 8) % 13), rnd[16:12]);
    end
    assemble(CondAl, OpHalt, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0);
    loadProgram(8'hFF, xorshift());
    runProgram();
    finishTest("aluOps");
  endtask

  // Four compares, each followed by EQ/NE/LT/GE xors into their own accumulator
  task automatic condTest();
    logic [3:0]  lhs [4];
    logic [3:0]  rhs [4];
    logic [15:0] a;
    resetCore();
    lhs = '{4'd1, 4'd1, 4'd7, 4'd1};  // Equal, unequal, negative vs positive, reverse
    rhs = '{4'd1, 4'd2, 4'd1, 4'd7};
    a   = {1'b0, 15'(xorshift())} | 16'h1;
    movImm(CondAl, 4'd1, a);
    movImm(CondAl, 4'd2, {1'b1, 15'(xorshift())});  // Differs from r1 in bit 15
    assemble(CondAl, OpSub, 1'b0, 4'd7, 4'd0, 4'd1, 5'd0);  // r7 = -r1
    for (int r = 3; r <= 6; r++)
      movImm(CondAl, 4'(r), 16'(xorshift()));  // Keys per case
    for (int k = 0; k < 4; k++)
    begin
      assemble(CondAl, OpCmp, 1'b0, 4'd0, lhs[k], rhs[k], 5'd0);
      assemble(CondEq, OpEor, 1'b0, 4'd9, 4'd9, 4'(3 + k), 5'd0);
      assemble(CondNe, OpEor, 1'b0, 4'd10, 4'd10, 4'(3 + k), 5'd0);
      assemble(CondLt, OpEor, 1'b0, 4'd11, 4'd11, 4'(3 + k), 5'd0);
      assemble(CondGe, OpEor, 1'b0, 4'd12, 4'd12, 4'(3 + k), 5'd0);
      assemble(CondNe, OpAdd, 1'b1, 4'd13, lhs[k], rhs[k], 5'd0);  // Flags move only if taken
    end
    assemble(CondAl, OpHalt, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0);
    loadProgram(8'hFF, xorshift());
    runProgram();
    finishTest("condFlags");
  endtask

  task automatic memTest();
    logic [AddrWidth-1:0] addr;
    logic [AddrWidth-1:0] slot;
    resetCore();
    addr = 8'd128 + 8'(xorshift() % 64);  // Store area clear of code
    slot = 8'd192 + 8'(xorshift() % 64);
    loadConst(4'd2, 4'd14, xorshift());
    movImm(CondAl, 4'd1, {8'd0, addr});
    assemble(CondAl, OpStr, 1'b0, 4'd0, 4'd1, 4'd2, 5'd0);
    assemble(CondAl, OpLdr, 1'b0, 4'd3, 4'd1, 4'd0, 5'd0);
    movImm(CondAl, 4'd4, {8'd0, slot});
    assemble(CondAl, OpLdr, 1'b0, 4'd5, 4'd4, 4'd0, 5'd0);
    assemble(CondAl, OpAdd, 1'b1, 4'd6, 4'd3, 4'd5, 5'd0);
    assemble(CondAl, OpHalt, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0);
    loadProgram(slot, xorshift());
    runProgram();
    finishTest("loadStore");
  endtask

  // Skipped slots write marker values into r15 and r14
  task automatic branchTest();
    logic [AddrWidth-1:0] base;
    resetCore();
    movImm(CondAl, 4'd1, 16'(xorshift()));
    base = AddrWidth'(prog.size());
    branchTo(CondAl, base + 8'd4);
    for (int i = 0; i < 3; i++)
      movImm(CondAl, 4'd15, 16'hDEAD);
    movImm(CondAl, 4'd2, 16'(xorshift()));
    assemble(CondAl, OpCmp, 1'b0, 4'd0, 4'd1, 4'd1, 5'd0);
    base = AddrWidth'(prog.size());
    branchTo(CondNe, base + 8'd2);  // Not taken
    branchTo(CondEq, base + 8'd4);  // Taken
    movImm(CondAl, 4'd15, 16'hDEAD);
    movImm(CondAl, 4'd15, 16'hDEAD);
    assemble(CondAl, OpHalt, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0);
    movImm(CondAl, 4'd14, 16'hBEEF);  // Past HALT
    loadProgram(8'hFF, xorshift());
    runProgram();
    finishTest("branchHalt");
  endtask

  initial
  begin
    rstN        = 1'b0;
    run         = 1'b0;
    progWe      = 1'b0;
    progAddr    = '0;
    progData    = '0;
    dbgAddr     = '0;
    rngState    = 32'd82;
    errCount    = 0;
    testsRun    = 0;
    testsFailed = 0;
    cycles      = 0;

    // Program loaded with run held low, core must stay parked
    resetCore();
    assemble(CondAl, OpHalt, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0);
    loadProgram(8'hFF, xorshift());
    repeat (20) @(posedge clk);
    finishTest("resetIdle");

    aluTest();
    condTest();
    memTest();
    branchTest();

    $display("Tests %0d, failing %0d, errors %0d", testsRun, testsFailed, errCount);
    if (errCount == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: filelist.f
rtl/cpuPkg.sv
rtl/unifiedRam.sv
rtl/memArbiter.sv
rtl/fetchSequencer.sv
rtl/registerBank.sv
rtl/masterAlu.sv
rtl/memoryControl.sv
rtl/cpuTop.sv
dv/cpuTb.sv

// File: rtl/cpuPkg.sv
// Core package with widths, opcodes, condition codes, flag bits and instruction fields
package cpuPkg;

  localparam int DataWidth    = 32;
  localparam int AddrWidth    = 8;   // RAM address and PC
  localparam int RegAddrWidth = 4;
  localparam int RamDepth     = 256;

  // Opcodes, ADD..MOV kept contiguous for the register write decode
  localparam logic [3:0] OpAdd  = 4'h0;
  localparam logic [3:0] OpSub  = 4'h1;
  localparam logic [3:0] OpAnd  = 4'h2;
  localparam logic [3:0] OpOrr  = 4'h3;
  localparam logic [3:0] OpEor  = 4'h4;
  localparam logic [3:0] OpLsl  = 4'h5;
  localparam logic [3:0] OpLsr  = 4'h6;
  localparam logic [3:0] OpMov  = 4'h7;
  localparam logic [3:0] OpCmp  = 4'h8;
  localparam logic [3:0] OpLdr  = 4'h9;
  localparam logic [3:0] OpStr  = 4'hA;
  localparam logic [3:0] OpB    = 4'hB;  // Absolute target in the immediate field
  localparam logic [3:0] OpHalt = 4'hF;

  // ARM-style condition encodings
  localparam logic [3:0] CondEq = 4'h0;
  localparam logic [3:0] CondNe = 4'h1;
  localparam logic [3:0] CondGe = 4'hA;
  localparam logic [3:0] CondLt = 4'hB;
  localparam logic [3:0] CondAl = 4'hE;

  // Bit positions in the NZCV word
  localparam int FlagN = 3;
  localparam int FlagZ = 2;
  localparam int FlagC = 1;
  localparam int FlagV = 0;

  // Instruction fields, MSB of each
  localparam int CondMsb = 31;
  localparam int OpMsb   = 27;
  localparam int SBit    = 23;
  localparam int RdMsb   = 22;
  localparam int Rs2Msb  = 18;
  localparam int Rs1Msb  = 14;
  localparam int ShMsb   = 10;  // 5-bit shift amount
  localparam int ImmMsb  = 18;  // 16-bit move immediate
  localparam int ImmLsb  = 3;

  // Arbiter port indices
  localparam logic [1:0] ReqLoad  = 2'd0;
  localparam logic [1:0] ReqData  = 2'd1;
  localparam logic [1:0] ReqFetch = 2'd2;

endpackage

// File: rtl/cpuTop.sv
// CPU top level wiring the core, memory arbiter and unified RAM
`timescale 1ns/1ns

module cpuTop (
  input  logic                            Clk_i,
  input  logic                            rstN_i,
  input  logic                            run_i,
  input  logic                            progWe_i,
  input  logic [cpuPkg::AddrWidth-1:0]    progAddr_i,
  input  logic [cpuPkg::DataWidth-1:0]    progData_i,
  input  logic [cpuPkg::RegAddrWidth-1:0] dbgAddr_i,
  output logic [cpuPkg::DataWidth-1:0]    dbgData_o,
  output logic [cpuPkg::AddrWidth-1:0]    pc_o,
  output logic [3:0]                      flags_o,
  output logic                            retire_o,
  output logic                            halted_o
);
  import cpuPkg::*;

  logic                 fetchReq;
  logic                 fetchGnt;
  logic                 dataReq;
  logic                 dataGnt;
  logic                 dataWe;
  logic [AddrWidth-1:0] dataAddr;
  logic [DataWidth-1:0] dataWdata;
  logic                 ramEn;
  logic                 ramWe;
  logic [AddrWidth-1:0] ramAddr;
  logic [DataWidth-1:0] ramWdata;
  logic [DataWidth-1:0] ramRdata;   // Shared read bus
  logic [DataWidth-1:0] instr;
  logic                 condPass;
  logic                 execStrobe;
  logic                 memStart;
  logic                 memDone;
  logic                 regWe;
  logic                 wbSelLoad;
  logic [DataWidth-1:0] rs1Data;
  logic [DataWidth-1:0] rs2Data;
  logic [DataWidth-1:0] aluResult;
  logic [DataWidth-1:0] loadData;

  unifiedRam u_ram (
    .Clk_i(Clk_i), .en_i(ramEn), .we_i(ramWe), .addr_i(ramAddr),
    .wdata_i(ramWdata), .rdata_o(ramRdata)
  );

  memArbiter u_arb (
    .Clk_i(Clk_i), .rstN_i(rstN_i),
    .loadReq_i(progWe_i), .loadAddr_i(progAddr_i), .loadData_i(progData_i),
    .dataReq_i(dataReq), .dataWe_i(dataWe), .dataAddr_i(dataAddr), .dataWdata_i(dataWdata),
    .fetchReq_i(fetchReq), .fetchAddr_i(pc_o),
    .loadGnt_o(), .dataGnt_o(dataGnt), .fetchGnt_o(fetchGnt),  // Load port never waits
    .ramEn_o(ramEn), .ramWe_o(ramWe), .ramAddr_o(ramAddr), .ramWdata_o(ramWdata)
  );

  fetchSequencer u_seq (
    .Clk_i(Clk_i), .rstN_i(rstN_i), .run_i(run_i),
    .fetchGnt_i(fetchGnt), .ramRdata_i(ramRdata), .condPass_i(condPass), .memDone_i(memDone),
    .fetchReq_o(fetchReq), .pc_o(pc_o), .instr_o(instr),
    .execStrobe_o(execStrobe), .memStart_o(memStart), .regWe_o(regWe),
    .wbSelLoad_o(wbSelLoad), .retire_o(retire_o), .halted_o(halted_o)
  );

  // Register indices straight from the instruction fields
  registerBank u_regs (
    .Clk_i(Clk_i), .rstN_i(rstN_i),
    .rs1Addr_i(instr[Rs1Msb -: RegAddrWidth]), .rs2Addr_i(instr[Rs2Msb -: RegAddrWidth]),
    .rdAddr_i(instr[RdMsb -: RegAddrWidth]), .we_i(regWe),
    .wdata_i(wbSelLoad ? loadData : aluResult),  // Writeback mux
    .rs1Data_o(rs1Data), .rs2Data_o(rs2Data),
    .dbgAddr_i(dbgAddr_i), .dbgData_o(dbgData_o)
  );

  masterAlu u_alu (
    .Clk_i(Clk_i), .rstN_i(rstN_i), .instr_i(instr),
    .rs1Data_i(rs1Data), .rs2Data_i(rs2Data), .execStrobe_i(execStrobe),
    .result_o(aluResult), .condPass_o(condPass), .flags_o(flags_o)
  );

  memoryControl u_lsu (
    .Clk_i(Clk_i), .rstN_i(rstN_i),
    .memStart_i(memStart), .isStore_i(instr[OpMsb -: 4] == OpStr),
    .rs1Data_i(rs1Data), .rs2Data_i(rs2Data),
    .dataGnt_i(dataGnt), .ramRdata_i(ramRdata),
    .dataReq_o(dataReq), .dataWe_o(dataWe), .dataAddr_o(dataAddr), .dataWdata_o(dataWdata),
    .loadData_o(loadData), .memDone_o(memDone)
  );

endmodule

// File: rtl/fetchSequencer.sv
// Fetch sequencer with PC, instruction register and the per-instruction FSM
`timescale 1ns/1ns

module fetchSequencer (
  input  logic                         Clk_i,
  input  logic                         rstN_i,
  input  logic                         run_i,
  input  logic                         fetchGnt_i,
  input  logic [cpuPkg::DataWidth-1:0] ramRdata_i,
  input  logic                         condPass_i,
  input  logic                         memDone_i,
  output logic                         fetchReq_o,
  output logic [cpuPkg::AddrWidth-1:0] pc_o,
  output logic [cpuPkg::DataWidth-1:0] instr_o,
  output logic                         execStrobe_o,
  output logic                         memStart_o,
  output logic                         regWe_o,
  output logic                         wbSelLoad_o,
  output logic                         retire_o,
  output logic                         halted_o
);
  import cpuPkg::*;

  typedef enum logic [2:0] {Idle, Fetch, Wait, Decode, Mem, Writeback, Halted} stateT;

  stateT      state;
  logic       passQ;      // Condition result sampled at decode
  logic [3:0] op;
  logic       isMem;
  logic       writesReg;

  assign op        = instr_o[OpMsb -: 4];
  assign isMem     = (op == OpLdr) || (op == OpStr);
  assign writesReg = (op inside {[OpAdd:OpMov]}) || (op == OpLdr);  // CMP/STR/B/HALT don't

  assign fetchReq_o   = (state == Fetch);  // Held until granted
  assign execStrobe_o = (state == Decode);
  assign memStart_o   = (state == Decode) && condPass_i && isMem;
  assign retire_o     = (state == Writeback);
  assign regWe_o      = retire_o && passQ && writesReg;
  assign wbSelLoad_o  = (op == OpLdr);
  assign halted_o     = (state == Halted);

  always_ff @(posedge Clk_i or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      state <= Idle;
      pc_o  <= '0;
      passQ <= 1'b0;
    end
    else if (!run_i)
    begin
      state <= Idle;  // Stopped core parks at address 0
      pc_o  <= '0;
    end
    else
    begin
      case (state)
        Idle:
          state <= Fetch;
        Fetch:
        begin
          if (fetchGnt_i)
            state <= Wait;  // Lost arbitration just stalls here
        end
        Wait:
          state <= Decode;  // RAM data latched below
        Decode:
        begin
          passQ <= condPass_i;
          state <= (condPass_i && isMem) ? Mem : Writeback;
        end
        Mem:
        begin
          if (memDone_i)
            state <= Writeback;
        end
        Writeback:
        begin
          // Taken branch loads the absolute target
          pc_o  <= (passQ && op == OpB) ? instr_o[ImmLsb +: AddrWidth] : pc_o + 1'b1;
          state <= (passQ && op == OpHalt) ? Halted : Fetch;
        end
        default:
          state <= state;  // Halted until run_i drops
      endcase
    end
  end

  // Instruction register, read data is valid the cycle after grant
  always_ff @(posedge Clk_i)
  begin
    if (state == Wait)
      instr_o <= ramRdata_i;
  end

  noRetireIdle: assert property (@(posedge Clk_i) disable iff (!rstN_i)
    (state inside {Idle, Halted}) |=> !retire_o)
    else $error("Retire straight out of idle or halted");

endmodule

// File: rtl/masterAlu.sv
// ALU with result datapath, NZCV flag register and condition check
`timescale 1ns/1ns

module masterAlu (
  input  logic                         Clk_i,
  input  logic                         rstN_i,
  input  logic [cpuPkg::DataWidth-1:0] instr_i,
  input  logic [cpuPkg::DataWidth-1:0] rs1Data_i,
  input  logic [cpuPkg::DataWidth-1:0] rs2Data_i,
  input  logic                         execStrobe_i,
  output logic [cpuPkg::DataWidth-1:0] result_o,
  output logic                         condPass_o,
  output logic [3:0]                   flags_o
);
  import cpuPkg::*;

  logic [3:0]         op;
  logic [3:0]         cond;
  logic [4:0]         shAmt;
  logic [DataWidth:0] sum;        // Carry out in the top bit
  logic               aSign;
  logic               bSign;
  logic               carry;
  logic               ovf;
  logic [3:0]         flagsNext;

  assign op    = instr_i[OpMsb -: 4];
  assign cond  = instr_i[CondMsb -: 4];
  assign shAmt = instr_i[ShMsb -: 5];
  assign aSign = rs1Data_i[DataWidth-1];
  assign bSign = rs2Data_i[DataWidth-1];

  always_comb
  begin
    sum      = '0;
    result_o = '0;
    carry    = flags_o[FlagC];  // Non-arithmetic ops keep C and V
    ovf      = flags_o[FlagV];
    case (op)
      OpAdd:
      begin
        sum      = {1'b0, rs1Data_i} + {1'b0, rs2Data_i};
        result_o = sum[DataWidth-1:0];
        carry    = sum[DataWidth];
        ovf      = (aSign == bSign) && (sum[DataWidth-1] != aSign);
      end
      OpSub, OpCmp:
      begin
        sum      = {1'b0, rs1Data_i} + {1'b0, ~rs2Data_i} + 1'b1;
        result_o = sum[DataWidth-1:0];
        carry    = sum[DataWidth];  // Set means no borrow
        ovf      = (aSign != bSign) && (sum[DataWidth-1] != aSign);
      end
      OpAnd: result_o = rs1Data_i & rs2Data_i;
      OpOrr: result_o = rs1Data_i | rs2Data_i;
      OpEor: result_o = rs1Data_i ^ rs2Data_i;
      OpLsl: result_o = rs1Data_i << shAmt;
      OpLsr: result_o = rs1Data_i >> shAmt;
      OpMov: result_o = {{(DataWidth-16){1'b0}}, instr_i[ImmMsb:ImmLsb]};
      default: result_o = '0;  // LDR, STR, B, HALT
    endcase
  end

  always_comb
  begin
    flagsNext        = '0;
    flagsNext[FlagN] = result_o[DataWidth-1];
    flagsNext[FlagZ] = (result_o == '0);
    flagsNext[FlagC] = carry;
    flagsNext[FlagV] = ovf;
  end

  // Checked against flags before this instruction updates them
  always_comb
  begin
    case (cond)
      CondAl:  condPass_o = 1'b1;
      CondEq:  condPass_o = flags_o[FlagZ];
      CondNe:  condPass_o = !flags_o[FlagZ];
      CondLt:  condPass_o = flags_o[FlagN] != flags_o[FlagV];
      CondGe:  condPass_o = flags_o[FlagN] == flags_o[FlagV];
      default: condPass_o = 1'b0;  // Unused codes never execute
    endcase
  end

  // S bit or CMP, only when the condition holds
  always_ff @(posedge Clk_i or negedge rstN_i)
  begin
    if (!rstN_i)
      flags_o <= '0;
    else if (execStrobe_i && condPass_o && (instr_i[SBit] || op == OpCmp))
      flags_o <= flagsNext;
  end

endmodule

// File: rtl/memArbiter.sv
// Memory arbiter granting the RAM to load port, load/store unit or fetch by fixed priority
`timescale 1ns/1ns

module memArbiter (
  input  logic                         Clk_i,
  input  logic                         rstN_i,
  input  logic                         loadReq_i,   // Program load, always a write
  input  logic [cpuPkg::AddrWidth-1:0] loadAddr_i,
  input  logic [cpuPkg::DataWidth-1:0] loadData_i,
  input  logic                         dataReq_i,
  input  logic                         dataWe_i,
  input  logic [cpuPkg::AddrWidth-1:0] dataAddr_i,
  input  logic [cpuPkg::DataWidth-1:0] dataWdata_i,
  input  logic                         fetchReq_i,  // Read only
  input  logic [cpuPkg::AddrWidth-1:0] fetchAddr_i,
  output logic                         loadGnt_o,
  output logic                         dataGnt_o,
  output logic                         fetchGnt_o,
  output logic                         ramEn_o,
  output logic                         ramWe_o,
  output logic [cpuPkg::AddrWidth-1:0] ramAddr_o,
  output logic [cpuPkg::DataWidth-1:0] ramWdata_o
);
  import cpuPkg::*;

  logic [2:0] reqVec;
  logic [2:0] gntVec;

  assign reqVec[ReqLoad]  = loadReq_i;
  assign reqVec[ReqData]  = dataReq_i;
  assign reqVec[ReqFetch] = fetchReq_i;

  // Load, then data, then fetch
  always_comb
  begin
    gntVec     = '0;
    ramWe_o    = 1'b0;
    ramAddr_o  = fetchAddr_i;  // Fetch path by default
    ramWdata_o = dataWdata_i;
    if (reqVec[ReqLoad])
    begin
      gntVec[ReqLoad] = 1'b1;
      ramWe_o         = 1'b1;
      ramAddr_o       = loadAddr_i;
      ramWdata_o      = loadData_i;
    end
    else if (reqVec[ReqData])
    begin
      gntVec[ReqData] = 1'b1;
      ramWe_o         = dataWe_i;
      ramAddr_o       = dataAddr_i;
    end
    else if (reqVec[ReqFetch])
      gntVec[ReqFetch] = 1'b1;
  end

  assign ramEn_o    = |reqVec;  // Any request wins a slot
  assign loadGnt_o  = gntVec[ReqLoad];
  assign dataGnt_o  = gntVec[ReqData];
  assign fetchGnt_o = gntVec[ReqFetch];

  gntOneHot: assert property (@(posedge Clk_i) disable iff (!rstN_i) $onehot0(gntVec))
    else $error("More than one grant, vector %b", gntVec);

  gntHasReq: assert property (@(posedge Clk_i) disable iff (!rstN_i)
    (gntVec & ~reqVec) == '0)
    else $error("Grant to idle port, gnt %b req %b (load bit %0d)", gntVec, reqVec, ReqLoad);

endmodule

// File: rtl/memoryControl.sv
// Load/store unit that requests the RAM and returns load data for writeback
`timescale 1ns/1ns

module memoryControl (
  input  logic                         Clk_i,
  input  logic                         rstN_i,
  input  logic                         memStart_i,
  input  logic                         isStore_i,
  input  logic [cpuPkg::DataWidth-1:0] rs1Data_i,
  input  logic [cpuPkg::DataWidth-1:0] rs2Data_i,
  input  logic                         dataGnt_i,
  input  logic [cpuPkg::DataWidth-1:0] ramRdata_i,
  output logic                         dataReq_o,
  output logic                         dataWe_o,
  output logic [cpuPkg::AddrWidth-1:0] dataAddr_o,
  output logic [cpuPkg::DataWidth-1:0] dataWdata_o,
  output logic [cpuPkg::DataWidth-1:0] loadData_o,
  output logic                         memDone_o
);
  import cpuPkg::*;

  logic                 busy;    // Request pending
  logic                 ack;     // Cycle after grant
  logic                 weQ;
  logic [AddrWidth-1:0] addrQ;
  logic [DataWidth-1:0] wdataQ;

  assign dataReq_o   = busy;
  assign dataWe_o    = weQ;
  assign dataAddr_o  = addrQ;
  assign dataWdata_o = wdataQ;
  assign memDone_o   = ack;

  always_ff @(posedge Clk_i or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      busy <= 1'b0;
      ack  <= 1'b0;
      weQ  <= 1'b0;
    end
    else
    begin
      ack <= busy && dataGnt_i;  // Read data lands the cycle after grant
      if (memStart_i)
      begin
        busy <= 1'b1;
        weQ  <= isStore_i;
      end
      else if (dataGnt_i)
        busy <= 1'b0;  // Drop request once granted
    end
  end

  // Address is the low byte of rs1, store data is rs2
  always_ff @(posedge Clk_i)
  begin
    if (memStart_i)
    begin
      addrQ  <= rs1Data_i[AddrWidth-1:0];
      wdataQ <= rs2Data_i;
    end
    if (ack && !weQ)
      loadData_o <= ramRdata_i;  // Held through writeback
  end

  noOverlap: assert property (@(posedge Clk_i) disable iff (!rstN_i)
    memStart_i |-> !busy && !ack)
    else $error("memStart while access still busy");

endmodule

// File: rtl/registerBank.sv
// Register bank of sixteen words, two read ports, one write port and a debug read
`timescale 1ns/1ns

module registerBank (
  input  logic                            Clk_i,
  input  logic                            rstN_i,
  input  logic [cpuPkg::RegAddrWidth-1:0] rs1Addr_i,
  input  logic [cpuPkg::RegAddrWidth-1:0] rs2Addr_i,
  input  logic [cpuPkg::RegAddrWidth-1:0] rdAddr_i,
  input  logic                            we_i,
  input  logic [cpuPkg::DataWidth-1:0]    wdata_i,
  output logic [cpuPkg::DataWidth-1:0]    rs1Data_o,
  output logic [cpuPkg::DataWidth-1:0]    rs2Data_o,
  input  logic [cpuPkg::RegAddrWidth-1:0] dbgAddr_i,
  output logic [cpuPkg::DataWidth-1:0]    dbgData_o
);
  import cpuPkg::*;

  logic [DataWidth-1:0] regs [2**RegAddrWidth];

  // Architectural state, cleared on reset
  always_ff @(posedge Clk_i or negedge rstN_i)
  begin
    if (!rstN_i)
    begin
      for (int i = 0; i < 2**RegAddrWidth; i++)
        regs[i] <= '0;
    end
    else if (we_i)
      regs[rdAddr_i] <= wdata_i;
  end

  // Combinational reads
  assign rs1Data_o = regs[rs1Addr_i];
  assign rs2Data_o = regs[rs2Addr_i];
  assign dbgData_o = regs[dbgAddr_i];  // Testbench readback

endmodule

// File: rtl/unifiedRam.sv
// Unified RAM holding code and data, single port with registered read data
`timescale 1ns/1ns

module unifiedRam (
  input  logic                         Clk_i,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [cpuPkg::AddrWidth-1:0] addr_i,
  input  logic [cpuPkg::DataWidth-1:0] wdata_i,
  output logic [cpuPkg::DataWidth-1:0] rdata_o
);
  import cpuPkg::*;

  logic [DataWidth-1:0] mem [RamDepth];

  always_ff @(posedge Clk_i)
  begin
    if (en_i)
    begin
      if (we_i)
        mem[addr_i] <= wdata_i;  // Write leaves rdata_o as it was
      else
        rdata_o <= mem[addr_i];  // Valid the cycle after enable
    end
  end

endmodule
